// ==== common/SchedulerPkg.sv ====
// Issue scheduler package.
// Queue and register sizes, the index and vector types, and the selector
// state shared by the matrix scheduler blocks.

package SchedulerPkg;

    // Queue and operand sizes.
    localparam int ENTRY_NUM = 8;
    localparam int SRC_NUM = 2;
    localparam int REG_NUM = 16;
    localparam int TAG_WIDTH = 8;

    // Derived widths.
    localparam int ENTRY_INDEX_WIDTH = $clog2(ENTRY_NUM);
    localparam int REG_INDEX_WIDTH = $clog2(REG_NUM);

    // Pointer to one issue queue entry.
    typedef logic [ENTRY_INDEX_WIDTH-1:0] EntryIndex;

    // One bit per issue queue entry.
    typedef logic [ENTRY_NUM-1:0] EntryOneHot;

    // Architectural register number.
    typedef logic [REG_INDEX_WIDTH-1:0] RegIndex;

    // Operation identifier carried from dispatch to issue.
    typedef logic [TAG_WIDTH-1:0] OpTag;

    // Selector activity.
    typedef enum logic {
        SEL_IDLE,
        SEL_ACTIVE
    } SelectState;

endpackage : SchedulerPkg

// ==== common/DispatchIf.sv ====
// Dispatch interface.
// One operation written into the issue queue: entry pointer, source
// readiness and producer pointers, destination register and tag.
`timescale 1ns/1ns

interface DispatchIf import SchedulerPkg::*; ();

    logic dispatch;
    EntryIndex dispatchPtr;
    logic [SRC_NUM-1:0] srcReady;
    EntryIndex [SRC_NUM-1:0] srcPtr;
    RegIndex dstReg;
    OpTag tag;

    // Driven by the allocator, the ready table and the top ports.
    modport source (
        output dispatch, dispatchPtr, srcReady, srcPtr, dstReg, tag
    );

    // Read by the matrix and the payload store.
    modport sink (
        input dispatch, dispatchPtr, srcReady, srcPtr, dstReg, tag
    );

endinterface : DispatchIf

// ==== hw/scheduler/ProducerMatrix.sv ====
// Producer dependency matrix.
// One row per queue entry, one column per producer entry. Wakeup clears
// producer columns, dispatch writes a row, and an all-zero row is ready.
`timescale 1ns/1ns

module ProducerMatrix import SchedulerPkg::*; (
    input logic clk,
    input logic stall,
    DispatchIf.sink disp,
    input EntryOneHot wakeup,
    output EntryOneHot opReady
);

    // Rows of invalid entries are don't care, the selector masks them.
    EntryOneHot [ENTRY_NUM-1:0] matrix;
    EntryOneHot [ENTRY_NUM-1:0] nextMatrix;
    EntryOneHot dispatchRow;

    always_ff @(posedge clk) begin
        matrix <= nextMatrix;
    end

    // Ready comes from the stored rows.
    // They already hold every wakeup up to the last edge.
    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            opReady[i] = !(|matrix[i]);
        end
    end

    // Producer bits for the dispatched operation.
    always_comb begin
        dispatchRow = '0;
        for (int s = 0; s < SRC_NUM; s++) begin
            // Not-ready sources name a producer still in the queue.
            if (!disp.srcReady[s]) begin
                dispatchRow[disp.srcPtr[s]] = 1'b1;
            end
        end
    end

    always_comb begin
        nextMatrix = matrix;

        // Clear the columns of issued producers in every row.
        for (int i = 0; i < ENTRY_NUM; i++) begin
            for (int j = 0; j < ENTRY_NUM; j++) begin
                if (wakeup[j]) begin
                    nextMatrix[i][j] = 1'b0;
                end
            end
        end

        // Frozen.
        if (stall) begin
            nextMatrix = matrix;
        end

        // New row replaces whatever the entry held before.
        if (disp.dispatch) begin
            nextMatrix[disp.dispatchPtr] = dispatchRow;
        end
    end

endmodule : ProducerMatrix

// ==== hw/scheduler/RegReadyTable.sv ====
// Register ready table.
// Keeps a ready bit and the producing entry for each register and turns
// source register numbers into ready bits and producer pointers.
`timescale 1ns/1ns

module RegReadyTable import SchedulerPkg::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic dispatch,
    input RegIndex [SRC_NUM-1:0] srcReg,
    input RegIndex dstReg,
    input EntryIndex dispatchPtr,
    input EntryOneHot wakeup,
    output logic [SRC_NUM-1:0] srcReady,
    output EntryIndex [SRC_NUM-1:0] srcPtr
);

    logic [REG_NUM-1:0] regReady;
    EntryIndex [REG_NUM-1:0] producer;

    // Lookup for the operation being dispatched.
    always_comb begin
        for (int s = 0; s < SRC_NUM; s++) begin
            srcPtr[s] = producer[srcReg[s]];
            // Bypass a producer that issues in this very cycle.
            srcReady[s] = regReady[srcReg[s]] || wakeup[producer[srcReg[s]]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regReady <= '1;
        end else if (!stall) begin
            for (int r = 0; r < REG_NUM; r++) begin
                if (wakeup[producer[r]]) begin
                    regReady[r] <= 1'b1;
                end
            end
            // Later assignment, so a new writer of the same register wins.
            if (dispatch) begin
                regReady[dstReg] <= 1'b0;
            end
        end
    end

    // Producer pointers matter only while the ready bit is clear.
    always_ff @(posedge clk) begin
        if (dispatch && !stall) begin
            producer[dstReg] <= dispatchPtr;
        end
    end

endmodule : RegReadyTable

// ==== hw/scheduler/EntryAllocator.sv ====
// Issue queue entry allocator.
// Holds the entry valid bits, chooses the lowest free entry for dispatch,
// releases entries on issue and raises full.
`timescale 1ns/1ns

module EntryAllocator import SchedulerPkg::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic opValid,
    input EntryOneHot wakeup,
    output logic dispatch,
    output EntryIndex dispatchPtr,
    output EntryOneHot entryValid,
    output logic full
);

    EntryOneHot freeEntries;
    EntryOneHot dispatchOneHot;

    assign freeEntries = ~entryValid;
    assign full = &entryValid;

    // Lowest free entry.
    always_comb begin
        dispatchPtr = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (freeEntries[i]) begin
                dispatchPtr = EntryIndex'(i);
            end
        end
    end

    assign dispatch = opValid && !full && !stall;

    always_comb begin
        dispatchOneHot = '0;
        if (dispatch) begin
            dispatchOneHot[dispatchPtr] = 1'b1;
        end
    end

    // Issued entry leaves and the dispatched one joins at the same edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (!stall) begin
            entryValid <= (entryValid & ~wakeup) | dispatchOneHot;
        end
    end

endmodule : EntryAllocator

// ==== hw/scheduler/IssueSelector.sv ====
// Issue selector.
// Picks the lowest ready and valid entry each cycle and sends its one-hot
// wakeup back to the matrix, the ready table and the allocator.
`timescale 1ns/1ns

module IssueSelector import SchedulerPkg::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input EntryOneHot opReady,
    input EntryOneHot entryValid,
    output logic issueValid,
    output EntryIndex issuePtr,
    output EntryOneHot wakeup
);

    SelectState state;
    SelectState nextState;
    EntryOneHot candidates;
    logic anyValid;
    logic issueEnable;

    assign anyValid = |entryValid;
    assign candidates = opReady & entryValid;

    // Lowest set index wins.
    always_comb begin
        issuePtr = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (candidates[i]) begin
                issuePtr = EntryIndex'(i);
            end
        end
    end

    // Issue only in SEL_ACTIVE.
    // It is entered one cycle after the queue stops being empty.
    assign issueEnable = (state == SEL_ACTIVE);
    assign issueValid = issueEnable && !stall && (|candidates);

    always_comb begin
        wakeup = '0;
        if (issueValid) begin
            wakeup[issuePtr] = 1'b1;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            SEL_IDLE: begin
                if (anyValid) begin
                    nextState = SEL_ACTIVE;
                end
            end
            SEL_ACTIVE: begin
                // Queue drains when the last valid entry issues.
                if ((entryValid & ~wakeup) == '0) begin
                    nextState = SEL_IDLE;
                end
            end
            default: nextState = SEL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEL_IDLE;
        end else if (!stall) begin
            state <= nextState;
        end
    end

endmodule : IssueSelector

// ==== hw/scheduler/IssuePayload.sv ====
// Issue payload store.
// Holds the tag and destination register of each queue entry and reads
// out the entry chosen for issue.
`timescale 1ns/1ns

module IssuePayload import SchedulerPkg::*; (
    input logic clk,
    DispatchIf.sink disp,
    input EntryIndex issuePtr,
    output OpTag issueTag,
    output RegIndex issueDstReg
);

    OpTag tagStore [ENTRY_NUM];
    RegIndex dstStore [ENTRY_NUM];

    // Written once per dispatch.
    always_ff @(posedge clk) begin
        if (disp.dispatch) begin
            tagStore[disp.dispatchPtr] <= disp.tag;
            dstStore[disp.dispatchPtr] <= disp.dstReg;
        end
    end

    // Asynchronous read of the issued entry.
    assign issueTag = tagStore[issuePtr];
    assign issueDstReg = dstStore[issuePtr];

endmodule : IssuePayload

// ==== hw/IssueScheduler.sv ====
// Matrix issue scheduler top level.
// One operation dispatched and one issued per cycle. The ready table feeds
// the dependency matrix, and the selector's wakeup closes the loop.
`timescale 1ns/1ns

module IssueScheduler import SchedulerPkg::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic opValid,
    input OpTag opTag,
    input RegIndex dstReg,
    input RegIndex srcReg0,
    input RegIndex srcReg1,
    output logic full,
    output logic issueValid,
    output OpTag issueTag,
    output RegIndex issueDstReg
);

    DispatchIf dispIf ();

    EntryOneHot wakeup;
    EntryOneHot opReady;
    EntryOneHot entryValid;
    EntryIndex issuePtr;

    // Operation fields straight from the ports.
    assign dispIf.dstReg = dstReg;
    assign dispIf.tag = opTag;

    EntryAllocator alloc_i (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .opValid(opValid),
        .wakeup(wakeup),
        .dispatch(dispIf.dispatch),
        .dispatchPtr(dispIf.dispatchPtr),
        .entryValid(entryValid),
        .full(full)
    );

    RegReadyTable table_i (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .dispatch(dispIf.dispatch),
        .srcReg({srcReg1, srcReg0}),
        .dstReg(dstReg),
        .dispatchPtr(dispIf.dispatchPtr),
        .wakeup(wakeup),
        .srcReady(dispIf.srcReady),
        .srcPtr(dispIf.srcPtr)
    );

    ProducerMatrix matrix_i (
        .clk(clk),
        .stall(stall),
        .disp(dispIf.sink),
        .wakeup(wakeup),
        .opReady(opReady)
    );

    IssueSelector selector_i (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .opReady(opReady),
        .entryValid(entryValid),
        .issueValid(issueValid),
        .issuePtr(issuePtr),
        .wakeup(wakeup)
    );

    IssuePayload payload_i (
        .clk(clk),
        .disp(dispIf.sink),
        .issuePtr(issuePtr),
        .issueTag(issueTag),
        .issueDstReg(issueDstReg)
    );

endmodule : IssueScheduler

// ==== tests/IssueSchedulerChecker.sv ====
// Issue scheduler checker.
// Keeps its own model of the queue and of register producers, and checks
// issue order, exactly-once issue, stall, full and empty behavior.
`timescale 1ns/1ns

module IssueSchedulerChecker import SchedulerPkg::*; (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic opValid,
    input OpTag opTag,
    input RegIndex dstReg,
    input RegIndex srcReg0,
    input RegIndex srcReg1,
    input logic full,
    input logic issueValid,
    input OpTag issueTag,
    input RegIndex issueDstReg,
    output int errorCount,
    output int outstanding
);

    localparam int TAG_NUM = 2 ** TAG_WIDTH;

    logic tagDispatched [TAG_NUM];
    logic tagIssued [TAG_NUM];
    RegIndex tagDst [TAG_NUM];
    OpTag tagProducer [TAG_NUM][SRC_NUM];
    logic tagHasProducer [TAG_NUM][SRC_NUM];
    OpTag lastWriter [REG_NUM];
    logic writerValid [REG_NUM];
    int pending = 0;
    int errors = 0;

    initial begin
        errorCount = 0;
        outstanding = 0;
    end

    always @(posedge clk) begin : watch
        OpTag t;
        RegIndex src [SRC_NUM];
        logic fullExp;
        if (rst) begin
            for (int i = 0; i < TAG_NUM; i++) begin
                tagDispatched[i] = 1'b0;
                tagIssued[i] = 1'b0;
            end
            for (int r = 0; r < REG_NUM; r++) begin
                writerValid[r] = 1'b0;
            end
            pending = 0;
        end else begin
            // Full reflects the occupancy at the start of the cycle.
            fullExp = (pending == ENTRY_NUM);
            if (full !== fullExp) begin
                $display("MISMATCH time=%0t full got=%0b expected=%0b", $time, full, fullExp);
                errors++;
            end
            if (pending == 0 && issueValid !== 1'b0) begin
                $display("Error at %0t: issue seen while the queue is empty", $time);
                errors++;
            end
            if (stall && issueValid) begin
                $display("Error at %0t: issue seen while stalled", $time);
                errors++;
            end
            if (issueValid === 1'b1) begin
                t = issueTag;
                if (!tagDispatched[t]) begin
                    $display("Error at %0t: tag %0d issued but never dispatched", $time, t);
                    errors++;
                end else if (tagIssued[t]) begin
                    $display("Error at %0t: tag %0d issued twice", $time, t);
                    errors++;
                end else begin
                    if (issueDstReg !== tagDst[t]) begin
                        $display("MISMATCH time=%0t issueDstReg got=%0d expected=%0d",
                            $time, issueDstReg, tagDst[t]);
                        errors++;
                    end
                    for (int s = 0; s < SRC_NUM; s++) begin
                        if (tagHasProducer[t][s] && !tagIssued[tagProducer[t][s]]) begin
                            $display("Error at %0t: tag %0d issued before its producer %0d",
                                $time, t, tagProducer[t][s]);
                            errors++;
                        end
                    end
                    tagIssued[t] = 1'b1;
                    pending--;
                end
            end
            // Accepted dispatch.
            // Producers are the last earlier writers of the sources.
            if (opValid && !fullExp && !stall) begin
                src[0] = srcReg0;
                src[1] = srcReg1;
                tagDispatched[opTag] = 1'b1;
                tagIssued[opTag] = 1'b0;
                tagDst[opTag] = dstReg;
                for (int s = 0; s < SRC_NUM; s++) begin
                    tagHasProducer[opTag][s] = writerValid[src[s]];
                    tagProducer[opTag][s] = lastWriter[src[s]];
                end
                lastWriter[dstReg] = opTag;
                writerValid[dstReg] = 1'b1;
                pending++;
            end
        end
        outstanding <= pending;
        errorCount <= errors;
    end

endmodule : IssueSchedulerChecker

// ==== tests/IssueSchedulerTb.sv ====
// Issue scheduler testbench.
// Applies a table of operations with stall gaps and dependency chains,
// waits for the queue to drain and prints the closing line.
`timescale 1ns/1ns

module IssueSchedulerTb import SchedulerPkg::*; ();

    localparam int ROWS = 24;
    localparam int CYCLE_LIMIT = ROWS * 8 + 100;

    logic clk;
    logic rst;
    logic stall;
    logic opValid;
    OpTag opTag;
    RegIndex dstReg;
    RegIndex srcReg0;
    RegIndex srcReg1;
    logic full;
    logic issueValid;
    OpTag issueTag;
    RegIndex issueDstReg;
    int checkErrors;
    int outstanding;
    int cycles = 0;
    int tbErrors = 0;
    int seed = 32'h66571b9e;

    // Stimulus table, one operation per row.
    OpTag tagTab [ROWS];
    RegIndex dstTab [ROWS];
    RegIndex src0Tab [ROWS];
    RegIndex src1Tab [ROWS];
    logic stallTab [ROWS];

    IssueScheduler dut_i (
        .clk(clk), .rst(rst), .stall(stall), .opValid(opValid),
        .opTag(opTag), .dstReg(dstReg), .srcReg0(srcReg0), .srcReg1(srcReg1),
        .full(full), .issueValid(issueValid), .issueTag(issueTag),
        .issueDstReg(issueDstReg)
    );

    IssueSchedulerChecker checker_i (
        .clk(clk), .rst(rst), .stall(stall), .opValid(opValid),
        .opTag(opTag), .dstReg(dstReg), .srcReg0(srcReg0), .srcReg1(srcReg1),
        .full(full), .issueValid(issueValid), .issueTag(issueTag),
        .issueDstReg(issueDstReg), .errorCount(checkErrors), .outstanding(outstanding)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic setRow(input int i, input int dst, input int s0, input int s1,
                          input logic st);
        tagTab[i] = OpTag'(i + 1);
        dstTab[i] = RegIndex'(dst);
        src0Tab[i] = RegIndex'(s0);
        src1Tab[i] = RegIndex'(s1);
        stallTab[i] = st;
    endtask

    task automatic fillTable();
        // Dependency chain starting at reg 0.
        // Rows three and four read a producer that issues in their dispatch cycle.
        setRow(0, 1, 0, 0, 1'b0);
        setRow(1, 2, 1, 1, 1'b0);
        setRow(2, 3, 2, 1, 1'b0);
        setRow(3, 4, 3, 2, 1'b0);
        setRow(4, 1, 4, 4, 1'b0);
        setRow(5, 5, 1, 3, 1'b0);
        setRow(6, 6, 5, 0, 1'b1);
        setRow(7, 7, 6, 6, 1'b0);
        // Independent operations on random registers of the upper half.
        for (int i = 8; i < 12; i++) begin
            setRow(i, 8 + ($random(seed) & 7), 8 + ($random(seed) & 7),
                8 + ($random(seed) & 7), 1'b0);
        end
        setRow(12, 9, 7, 5, 1'b1);
        for (int i = 13; i < 18; i++) begin
            setRow(i, 2, 2, i % 4, 1'b0);
        end
        for (int i = 18; i < ROWS; i++) begin
            setRow(i, 8 + ($random(seed) & 7), 8 + ($random(seed) & 7),
                i % 16, (i == 20));
        end
    endtask

    task automatic finishRun();
        int total;
        // Let the checker's counts from the last edge settle.
        @(negedge clk);
        total = tbErrors + checkErrors;
        $display("Errors: %0d (checker %0d, testbench %0d)", total, checkErrors, tbErrors);
        if (total == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Error: timeout, not all operations issued");
            tbErrors++;
            finishRun();
        end
    end

    initial begin
        rst = 1'b1;
        stall = 1'b0;
        opValid = 1'b0;
        opTag = '0;
        dstReg = '0;
        srcReg0 = '0;
        srcReg1 = '0;
        fillTable();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < ROWS; i++) begin
            if (stallTab[i]) begin
                // Freeze the scheduler for a few cycles before this row.
                stall <= 1'b1;
                opValid <= 1'b0;
                repeat (3) @(posedge clk);
                stall <= 1'b0;
            end
            opValid <= 1'b1;
            opTag <= tagTab[i];
            dstReg <= dstTab[i];
            srcReg0 <= src0Tab[i];
            srcReg1 <= src1Tab[i];
            @(posedge clk);
            while (full) begin
                @(posedge clk);
            end
        end
        opValid <= 1'b0;
        @(posedge clk);
        while (outstanding != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        finishRun();
    end

endmodule : IssueSchedulerTb

// ==== flist.f ====
common/SchedulerPkg.sv
common/DispatchIf.sv
hw/scheduler/ProducerMatrix.sv
hw/scheduler/RegReadyTable.sv
hw/scheduler/EntryAllocator.sv
hw/scheduler/IssueSelector.sv
hw/scheduler/IssuePayload.sv
hw/IssueScheduler.sv
tests/IssueSchedulerChecker.sv
tests/IssueSchedulerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the issue scheduler simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module IssueSchedulerTb -o simv

out=$(./obj_dir/simv)
echo "$out"

# Pass only when the pass message was printed.
echo "$out" | grep -q "Test OK"
